/* source/pcim_defines.svh */
`ifndef PCIM_DEFINES_SVH
`define PCIM_DEFINES_SVH

// host bus and command field widths
`define PCIM_ADDR_W 32
`define PCIM_DATA_W 32
`define PCIM_LEN_W 8
`define PCIM_CNT_W 16

// capacity behind each command link, which is also the producer's starting credit
`define PCIM_FIFO_DEPTH 3
`define PCIM_ENGINE_SLOTS 1

// config register map
`define PCIM_REG_CTRL   32'h0000_0000
`define PCIM_REG_BASE   32'h0000_0004
`define PCIM_REG_LEN    32'h0000_0008
`define PCIM_REG_COUNT  32'h0000_000C
`define PCIM_REG_SEED   32'h0000_0010
`define PCIM_REG_MODE   32'h0000_0014
`define PCIM_REG_STATUS 32'h0000_0018
`define PCIM_REG_ERRS   32'h0000_001C

`endif

/* source/pcim_pkg.sv */
`include "pcim_defines.svh"

package pcim_pkg;

  typedef enum logic {
    op_write,
    op_read
  } pcim_op_e;

  // write_read issues every write first, then reads the same range back
  typedef enum logic [1:0] {
    mode_write,
    mode_read,
    mode_write_read
  } pcim_mode_e;

  typedef enum logic [1:0] {
    atg_idle,
    atg_issue,
    atg_drain
  } pcim_atg_state_e;

  typedef enum logic {
    eng_idle,
    eng_run
  } pcim_eng_state_e;

  // first marks the opening command of a program so the engine can clear its counters
  typedef struct packed {
    pcim_op_e                op;
    logic [`PCIM_ADDR_W-1:0] addr;
    logic [`PCIM_LEN_W-1:0]  len;
    logic [`PCIM_DATA_W-1:0] seed;
    logic                    first;
  } pcim_cmd_t;

endpackage

/* source/pcim_cmd_if.sv */
`timescale 1ns/1ps

// credit based command link
// the producer starts out owning one credit per consumer slot and spends one per valid
// cycle, and the consumer hands a credit back with a one cycle pulse whenever a slot
// frees up, so there is no ready signal and a valid command is always taken
interface pcim_cmd_if import pcim_pkg::*; ();

  logic      valid;
  pcim_cmd_t cmd;
  logic      credit;

  modport producer (
    output valid,
    output cmd,
    input  credit
  );

  modport consumer (
    input  valid,
    input  cmd,
    output credit
  );

endinterface

/* source/pcim_atg.sv */
`timescale 1ns/1ps
`include "pcim_defines.svh"

module pcim_atg import pcim_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`PCIM_ADDR_W-1:0] cfg_addr,
  input  logic [`PCIM_DATA_W-1:0] cfg_wdata,
  input  logic                    cfg_wr,
  input  logic                    cfg_rd,
  output logic                    cfg_ack,
  output logic [`PCIM_DATA_W-1:0] cfg_rdata,
  pcim_cmd_if.producer            cmd,
  input  logic [`PCIM_CNT_W-1:0]  cmds_done,
  input  logic [`PCIM_CNT_W-1:0]  err_count
);

  localparam int CRED_W = $clog2(`PCIM_FIFO_DEPTH + 1);

  pcim_atg_state_e         state;
  pcim_mode_e              mode_reg;
  pcim_op_e                phase_op;
  logic [`PCIM_DATA_W-1:0] ctrl_reg;
  logic [`PCIM_DATA_W-1:0] seed_reg;
  logic [`PCIM_DATA_W-1:0] cur_seed;
  logic [`PCIM_DATA_W-1:0] rd_val;
  logic [`PCIM_ADDR_W-1:0] base_reg;
  logic [`PCIM_ADDR_W-1:0] cur_addr;
  logic [`PCIM_ADDR_W-1:0] stride;
  logic [`PCIM_LEN_W-1:0]  len_reg;
  logic [`PCIM_CNT_W-1:0]  count_reg;
  logic [`PCIM_CNT_W-1:0]  cmd_idx;
  logic [`PCIM_CNT_W:0]    target;
  logic [CRED_W-1:0]       credits;
  logic [CRED_W-1:0]       avail;
  logic                    busy;
  logic                    start;
  logic                    send;
  logic                    first_pend;
  logic                    phase_done;
  logic                    read_next;

  // --------------------------------------------------
  // config registers
  // --------------------------------------------------
  assign busy  = (state != atg_idle);
  assign start = cfg_wr && !busy && (cfg_addr == `PCIM_REG_CTRL) && cfg_wdata[0] &&
                 (count_reg != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_reg  <= '0;
      base_reg  <= '0;
      len_reg   <= '0;
      count_reg <= '0;
      seed_reg  <= '0;
      mode_reg  <= mode_write;
      cfg_ack   <= 1'b0;
    end else begin
      cfg_ack <= cfg_wr || cfg_rd;
      // the program parameters are frozen while a program runs
      if (cfg_wr && !busy) begin
        case (cfg_addr)
          `PCIM_REG_CTRL:  ctrl_reg  <= cfg_wdata;
          `PCIM_REG_BASE:  base_reg  <= cfg_wdata;
          `PCIM_REG_LEN:   len_reg   <= cfg_wdata[`PCIM_LEN_W-1:0];
          `PCIM_REG_COUNT: count_reg <= cfg_wdata[`PCIM_CNT_W-1:0];
          `PCIM_REG_SEED:  seed_reg  <= cfg_wdata;
          `PCIM_REG_MODE:  mode_reg  <= pcim_mode_e'(cfg_wdata[1:0]);
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (cfg_addr)
      `PCIM_REG_CTRL:   rd_val = ctrl_reg;
      `PCIM_REG_BASE:   rd_val = base_reg;
      `PCIM_REG_LEN:    rd_val = `PCIM_DATA_W'(len_reg);
      `PCIM_REG_COUNT:  rd_val = `PCIM_DATA_W'(count_reg);
      `PCIM_REG_SEED:   rd_val = seed_reg;
      `PCIM_REG_MODE:   rd_val = `PCIM_DATA_W'(mode_reg);
      `PCIM_REG_STATUS: rd_val = {cmds_done, {(`PCIM_DATA_W-`PCIM_CNT_W-1){1'b0}}, busy};
      `PCIM_REG_ERRS:   rd_val = `PCIM_DATA_W'(err_count);
      default:          rd_val = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (cfg_rd) begin
      cfg_rdata <= rd_val;
    end
  end

  // --------------------------------------------------
  // command sequencer
  // --------------------------------------------------
  // a credit spent by the valid now on the link is not yet off the counter
  assign avail  = credits - CRED_W'(cmd.valid);
  assign send   = (state == atg_issue) && (avail != '0);
  assign stride = (`PCIM_ADDR_W'(len_reg) + 1'b1) << 2;

  // the engine counts every command of the program, the read phase included
  assign target = (mode_reg == mode_write_read && phase_op == op_read) ?
                  {count_reg, 1'b0} : {1'b0, count_reg};

  // all credits home means the first command already cleared the engine counters
  assign phase_done = (state == atg_drain) && !cmd.valid &&
                      (credits == CRED_W'(`PCIM_FIFO_DEPTH)) && ({1'b0, cmds_done} == target);
  assign read_next  = phase_done && (mode_reg == mode_write_read) && (phase_op == op_write);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= atg_idle;
      phase_op   <= op_write;
      cmd_idx    <= '0;
      first_pend <= 1'b0;
      cmd.valid  <= 1'b0;
      credits    <= CRED_W'(`PCIM_FIFO_DEPTH);
    end else begin
      cmd.valid <= send;
      credits   <= credits - CRED_W'(cmd.valid) + CRED_W'(cmd.credit);
      case (state)
        atg_idle: begin
          if (start) begin
            state      <= atg_issue;
            cmd_idx    <= '0;
            first_pend <= 1'b1;
            phase_op   <= (mode_reg == mode_read) ? op_read : op_write;
          end
        end
        atg_issue: begin
          if (send) begin
            cmd_idx    <= cmd_idx + 1'b1;
            first_pend <= 1'b0;
            if (cmd_idx == count_reg - 1'b1) begin
              state <= atg_drain;
            end
          end
        end
        atg_drain: begin
          if (read_next) begin
            state    <= atg_issue;
            phase_op <= op_read;
            cmd_idx  <= '0;
          end else if (phase_done) begin
            state <= atg_idle;
          end
        end
        default: state <= atg_idle;
      endcase
    end
  end

  // command k starts at base + k * (len + 1) * 4 and carries seed + k
  always_ff @(posedge clk) begin
    if (start || read_next) begin
      cur_addr <= base_reg;
      cur_seed <= seed_reg;
    end else if (send) begin
      cur_addr <= cur_addr + stride;
      cur_seed <= cur_seed + 1'b1;
    end
    if (send) begin
      cmd.cmd <= '{op: phase_op, addr: cur_addr, len: len_reg, seed: cur_seed,
                   first: first_pend};
    end
  end

  // a credit returned while every credit is already home would push the counter past the depth
  a_credit_bound: assert property (
    @(posedge clk) disable iff (!rst_n) cmd.credit |-> avail < CRED_W'(`PCIM_FIFO_DEPTH))
    else $error("atg credit counter above fifo depth");

  a_valid_has_credit: assert property (
    @(posedge clk) disable iff (!rst_n) cmd.valid |-> credits != '0)
    else $error("atg sent a command without a credit");

endmodule

/* source/pcim_flop_fifo.sv */
`timescale 1ns/1ps
`include "pcim_defines.svh"

module pcim_flop_fifo import pcim_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  pcim_cmd_if.consumer up,
  pcim_cmd_if.producer dn
);

  localparam int DEPTH  = `PCIM_FIFO_DEPTH;
  localparam int PTR_W  = $clog2(DEPTH);
  localparam int FILL_W = $clog2(DEPTH + 1);
  localparam int CRED_W = $clog2(`PCIM_ENGINE_SLOTS + 1);

  pcim_cmd_t         mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [FILL_W-1:0] fill;
  logic [CRED_W-1:0] dn_credits;
  logic              pop;

  // --------------------------------------------------
  // pop side
  // --------------------------------------------------
  // an entry leaves as soon as it is stored and the engine has a free slot
  assign pop      = (fill != '0) && (dn_credits != '0);
  assign dn.valid = pop;
  assign dn.cmd   = mem[rd_ptr];

  // every pop frees an entry, so the generator gets its credit back right away
  assign up.credit = pop;

  // --------------------------------------------------
  // storage and pointers
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (up.valid) begin
      mem[wr_ptr] <= up.cmd;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill       <= '0;
      dn_credits <= CRED_W'(`PCIM_ENGINE_SLOTS);
    end else begin
      if (up.valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      fill       <= fill + FILL_W'(up.valid) - FILL_W'(pop);
      dn_credits <= dn_credits - CRED_W'(pop) + CRED_W'(dn.credit);
    end
  end

  // the generator's credit count must keep it from overrunning the buffer
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!rst_n) up.valid |-> fill != FILL_W'(DEPTH))
    else $error("fifo pushed while full");

  // the pointers must show a stored entry whenever one is handed downstream
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    dn.valid |-> wr_ptr != rd_ptr || fill == FILL_W'(DEPTH))
    else $error("fifo popped while empty");

endmodule

/* source/pcim_beat_engine.sv */
`timescale 1ns/1ps
`include "pcim_defines.svh"

module pcim_beat_engine import pcim_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  pcim_cmd_if.consumer            cmd,
  output logic                    hst_valid,
  output logic                    hst_write,
  output logic [`PCIM_ADDR_W-1:0] hst_addr,
  output logic [`PCIM_DATA_W-1:0] hst_wdata,
  output logic                    hst_last,
  input  logic                    hst_ready,
  input  logic                    hst_rvalid,
  input  logic [`PCIM_DATA_W-1:0] hst_rdata,
  output logic [`PCIM_CNT_W-1:0]  cmds_done,
  output logic [`PCIM_CNT_W-1:0]  err_count
);

  pcim_eng_state_e         state;
  pcim_op_e                cur_op;
  logic [`PCIM_LEN_W-1:0]  cur_len;
  logic [`PCIM_LEN_W-1:0]  beat_idx;
  logic [`PCIM_LEN_W-1:0]  rsp_idx;
  logic [`PCIM_DATA_W-1:0] cur_seed;
  logic                    accept;
  logic                    beat_fire;
  logic                    rsp_fire;
  logic                    cmd_done;

  assign accept    = (state == eng_idle) && cmd.valid;
  assign beat_fire = hst_valid && hst_ready;
  assign rsp_fire  = (state == eng_run) && (cur_op == op_read) && hst_rvalid;

  // writes finish on the last accepted beat, reads on the last returned word
  assign cmd_done = (state == eng_run) &&
                    ((cur_op == op_write) ? (beat_fire && hst_last) :
                                            (rsp_fire && rsp_idx == cur_len));

  // --------------------------------------------------
  // control and counters
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= eng_idle;
      hst_valid  <= 1'b0;
      hst_last   <= 1'b0;
      beat_idx   <= '0;
      rsp_idx    <= '0;
      cmds_done  <= '0;
      err_count  <= '0;
      cmd.credit <= 1'b0;
    end else begin
      cmd.credit <= cmd_done;
      if (accept) begin
        state     <= eng_run;
        hst_valid <= 1'b1;
        hst_last  <= (cmd.cmd.len == '0);
        beat_idx  <= '0;
        rsp_idx   <= '0;
        if (cmd.cmd.first) begin
          cmds_done <= '0;
          err_count <= '0;
        end
      end
      if (beat_fire) begin
        if (hst_last) begin
          hst_valid <= 1'b0;
        end else begin
          beat_idx <= beat_idx + 1'b1;
          hst_last <= (beat_idx + 1'b1 == cur_len);
        end
      end
      if (rsp_fire) begin
        rsp_idx <= rsp_idx + 1'b1;
        if (hst_rdata != cur_seed + `PCIM_DATA_W'(rsp_idx)) begin
          err_count <= err_count + 1'b1;
        end
      end
      if (cmd_done) begin
        state     <= eng_idle;
        cmds_done <= cmds_done + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // beat payload
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (accept) begin
      cur_op    <= cmd.cmd.op;
      cur_len   <= cmd.cmd.len;
      cur_seed  <= cmd.cmd.seed;
      hst_write <= (cmd.cmd.op == op_write);
      hst_addr  <= cmd.cmd.addr;
      hst_wdata <= cmd.cmd.seed;
    end else if (beat_fire && !hst_last) begin
      hst_addr  <= hst_addr + 3'd4;
      hst_wdata <= hst_wdata + 1'b1;
    end
  end

  // the single engine slot is only offered while the previous command is finished
  a_cmd_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n) cmd.valid |-> state == eng_idle)
    else $error("engine got a command while busy");

  a_beat_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    hst_valid && !hst_ready |=> hst_valid && $stable(hst_addr) && $stable(hst_wdata))
    else $error("host beat changed before it was accepted");

endmodule

/* source/pcim_mstr.sv */
`timescale 1ns/1ps
`include "pcim_defines.svh"

module pcim_mstr (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`PCIM_ADDR_W-1:0] cfg_addr,
  input  logic [`PCIM_DATA_W-1:0] cfg_wdata,
  input  logic                    cfg_wr,
  input  logic                    cfg_rd,
  output logic                    cfg_ack,
  output logic [`PCIM_DATA_W-1:0] cfg_rdata,
  output logic                    hst_valid,
  output logic                    hst_write,
  output logic [`PCIM_ADDR_W-1:0] hst_addr,
  output logic [`PCIM_DATA_W-1:0] hst_wdata,
  output logic                    hst_last,
  input  logic                    hst_ready,
  input  logic                    hst_rvalid,
  input  logic [`PCIM_DATA_W-1:0] hst_rdata
);

  logic [`PCIM_CNT_W-1:0] cmds_done;
  logic [`PCIM_CNT_W-1:0] err_count;

  pcim_cmd_if atg_to_fifo ();
  pcim_cmd_if fifo_to_eng ();

  // --------------------------------------------------
  // traffic generator, command buffer, beat engine
  // --------------------------------------------------
  pcim_atg atg_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_wr    (cfg_wr),
    .cfg_rd    (cfg_rd),
    .cfg_ack   (cfg_ack),
    .cfg_rdata (cfg_rdata),
    .cmd       (atg_to_fifo.producer),
    .cmds_done (cmds_done),
    .err_count (err_count)
  );

  pcim_flop_fifo fifo_i (
    .clk   (clk),
    .rst_n (rst_n),
    .up    (atg_to_fifo.consumer),
    .dn    (fifo_to_eng.producer)
  );

  pcim_beat_engine eng_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd        (fifo_to_eng.consumer),
    .hst_valid  (hst_valid),
    .hst_write  (hst_write),
    .hst_addr   (hst_addr),
    .hst_wdata  (hst_wdata),
    .hst_last   (hst_last),
    .hst_ready  (hst_ready),
    .hst_rvalid (hst_rvalid),
    .hst_rdata  (hst_rdata),
    .cmds_done  (cmds_done),
    .err_count  (err_count)
  );

endmodule

/* test/pcim_host_model.sv */
`timescale 1ns/1ps
`include "pcim_defines.svh"

module pcim_host_model (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    hst_valid,
  input  logic                    hst_write,
  input  logic [`PCIM_ADDR_W-1:0] hst_addr,
  input  logic [`PCIM_DATA_W-1:0] hst_wdata,
  input  logic                    hst_ready,
  input  logic [1:0]              rd_lat,
  input  logic                    corrupt,
  output logic                    hst_rvalid,
  output logic [`PCIM_DATA_W-1:0] hst_rdata
);

  logic [`PCIM_DATA_W-1:0] mem [logic [`PCIM_ADDR_W-1:0]];
  logic [`PCIM_DATA_W-1:0] rsp_data [$];
  int                      rsp_due [$];
  int                      cyc;

  initial begin
    hst_rvalid = 1'b0;
    hst_rdata  = '0;
    cyc        = 0;
  end

  // --------------------------------------------------
  // request side
  // --------------------------------------------------
  // beats are taken mid cycle, the transfer itself happens on the next rising edge
  always @(negedge clk) begin
    if (rst_n && hst_valid && hst_ready) begin
      if (hst_write) begin
        // with corruption on, words on a 64 byte boundary are stored with bit 0 flipped
        if (corrupt && hst_addr[5:0] == 6'd0) begin
          mem[hst_addr] = hst_wdata ^ `PCIM_DATA_W'(1);
        end else begin
          mem[hst_addr] = hst_wdata;
        end
      end else begin
        rsp_data.push_back(mem.exists(hst_addr) ? mem[hst_addr] : ~hst_addr);
        rsp_due.push_back(cyc + 1 + int'(rd_lat));
      end
    end
  end

  // --------------------------------------------------
  // response side
  // --------------------------------------------------
  // responses leave in request order, a late head holds back the ones behind it
  always @(posedge clk) begin
    cyc = cyc + 1;
    #1;
    if (rsp_due.size() != 0 && rsp_due[0] <= cyc) begin
      hst_rvalid = 1'b1;
      hst_rdata  = rsp_data.pop_front();
      void'(rsp_due.pop_front());
    end else begin
      hst_rvalid = 1'b0;
    end
  end

endmodule

/* test/tb_pcim_mstr.sv */
`timescale 1ns/1ps
`include "pcim_defines.svh"

module tb_pcim_mstr import pcim_pkg::*; ();

  localparam int NUM_PROGRAMS = 6;
  localparam int POLL_CYCLES  = 5000;

  typedef struct packed {
    pcim_mode_e              mode;
    logic [`PCIM_ADDR_W-1:0] base;
    logic [`PCIM_LEN_W-1:0]  len;
    logic [`PCIM_CNT_W-1:0]  count;
    logic [`PCIM_DATA_W-1:0] seed;
    logic                    corrupt;
    logic                    bp;
    logic [`PCIM_CNT_W-1:0]  errs;
  } program_row_t;

  logic                    clk;
  logic                    rst_n;
  logic [`PCIM_ADDR_W-1:0] cfg_addr;
  logic [`PCIM_DATA_W-1:0] cfg_wdata;
  logic                    cfg_wr;
  logic                    cfg_rd;
  logic                    cfg_ack;
  logic [`PCIM_DATA_W-1:0] cfg_rdata;
  logic                    hst_valid;
  logic                    hst_write;
  logic [`PCIM_ADDR_W-1:0] hst_addr;
  logic [`PCIM_DATA_W-1:0] hst_wdata;
  logic                    hst_last;
  logic                    hst_ready;
  logic                    hst_rvalid;
  logic [`PCIM_DATA_W-1:0] hst_rdata;
  logic [1:0]              rd_lat;
  logic                    corrupt;
  logic                    bp_on;
  logic [31:0]             lfsr;
  logic                    ready_bit;
  logic [1:0]              lat_bits;
  logic [`PCIM_DATA_W-1:0] rd_word;

  program_row_t            programs [NUM_PROGRAMS];
  pcim_mode_e              cur_mode;
  logic [`PCIM_ADDR_W-1:0] cur_base;
  logic [`PCIM_DATA_W-1:0] cur_seed;
  pcim_op_e                exp_op;
  int                      cur_len;
  int                      cur_count;
  int                      beat_n;
  int                      total_beats;
  int                      bpp;
  int                      idx;
  int                      k;
  int                      i;

  pcim_mstr pcim_mstr_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .cfg_wr     (cfg_wr),
    .cfg_rd     (cfg_rd),
    .cfg_ack    (cfg_ack),
    .cfg_rdata  (cfg_rdata),
    .hst_valid  (hst_valid),
    .hst_write  (hst_write),
    .hst_addr   (hst_addr),
    .hst_wdata  (hst_wdata),
    .hst_last   (hst_last),
    .hst_ready  (hst_ready),
    .hst_rvalid (hst_rvalid),
    .hst_rdata  (hst_rdata)
  );

  pcim_host_model host_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .hst_valid  (hst_valid),
    .hst_write  (hst_write),
    .hst_addr   (hst_addr),
    .hst_wdata  (hst_wdata),
    .hst_ready  (hst_ready),
    .rd_lat     (rd_lat),
    .corrupt    (corrupt),
    .hst_rvalid (hst_rvalid),
    .hst_rdata  (hst_rdata)
  );

  initial begin
    clk = 1'b0;
  end

  always #50 clk = ~clk;

  // --------------------------------------------------
  // reporting and checks
  // --------------------------------------------------
  task automatic stop_on_error();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_data(input logic [`PCIM_DATA_W-1:0] got,
                            input logic [`PCIM_DATA_W-1:0] exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_count(input logic [`PCIM_CNT_W-1:0] got,
                             input logic [`PCIM_CNT_W-1:0] exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_op(input pcim_op_e got, input pcim_op_e exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
      stop_on_error();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  // feedback polynomial x^32 + x^22 + x^2 + x + 1 on a right shifting register
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // --------------------------------------------------
  // config bus
  // --------------------------------------------------
  // each access starts 1 ns after a rising edge and ends at the same point
  task automatic cfg_write(input logic [`PCIM_ADDR_W-1:0] addr,
                           input logic [`PCIM_DATA_W-1:0] data);
    cfg_addr  = addr;
    cfg_wdata = data;
    cfg_wr    = 1'b1;
    @(posedge clk);
    #1 cfg_wr = 1'b0;
    @(negedge clk);
    check_flag(cfg_ack, 1'b1, "cfg_ack after write strobe");
    @(negedge clk);
    check_flag(cfg_ack, 1'b0, "cfg_ack one cycle later");
    @(posedge clk);
    #1;
  endtask

  task automatic cfg_read(input logic [`PCIM_ADDR_W-1:0] addr,
                          output logic [`PCIM_DATA_W-1:0] data);
    cfg_addr = addr;
    cfg_rd   = 1'b1;
    @(posedge clk);
    #1 cfg_rd = 1'b0;
    @(negedge clk);
    check_flag(cfg_ack, 1'b1, "cfg_ack after read strobe");
    data = cfg_rdata;
    @(negedge clk);
    check_flag(cfg_ack, 1'b0, "cfg_ack one cycle later");
    @(posedge clk);
    #1;
  endtask

  task automatic write_and_read_back(input logic [`PCIM_ADDR_W-1:0] addr,
                                     input logic [`PCIM_DATA_W-1:0] data,
                                     input logic [`PCIM_DATA_W-1:0] exp);
    logic [`PCIM_DATA_W-1:0] got;
    cfg_write(addr, data);
    cfg_read(addr, got);
    check_data(got, exp, "register read back");
  endtask

  task automatic run_program(input program_row_t row);
    logic [`PCIM_DATA_W-1:0] st;
    int                      waited;
    int                      phases;
    phases      = (row.mode == mode_write_read) ? 2 : 1;
    cur_mode    = row.mode;
    cur_base    = row.base;
    cur_seed    = row.seed;
    cur_len     = int'(row.len);
    cur_count   = int'(row.count);
    beat_n      = 0;
    total_beats = cur_count * (cur_len + 1) * phases;
    bp_on       = row.bp;
    corrupt     = row.corrupt;
    cfg_write(`PCIM_REG_BASE, row.base);
    cfg_write(`PCIM_REG_LEN, `PCIM_DATA_W'(row.len));
    cfg_write(`PCIM_REG_COUNT, `PCIM_DATA_W'(row.count));
    cfg_write(`PCIM_REG_SEED, row.seed);
    cfg_write(`PCIM_REG_MODE, `PCIM_DATA_W'(row.mode));
    cfg_write(`PCIM_REG_CTRL, `PCIM_DATA_W'(1));
    st     = `PCIM_DATA_W'(1);
    waited = 0;
    // one status read takes three clock cycles
    while (st[0] && waited < POLL_CYCLES) begin
      cfg_read(`PCIM_REG_STATUS, st);
      waited = waited + 3;
    end
    if (st[0]) begin
      $display("busy bit still set after %0d cycles of polling status", POLL_CYCLES);
      stop_on_error();
    end
    check_count(`PCIM_CNT_W'(beat_n), `PCIM_CNT_W'(total_beats), "host beat count");
    check_count(st[31:16], `PCIM_CNT_W'(cur_count * phases), "cmds_done");
    cfg_read(`PCIM_REG_ERRS, st);
    check_count(st[`PCIM_CNT_W-1:0], row.errs, "err_count");
  endtask

  // --------------------------------------------------
  // host port stimulus and beat monitor
  // --------------------------------------------------
  always @(posedge clk) begin
    #1;
    if (bp_on) begin
      lfsr        = lfsr_step(lfsr);
      ready_bit   = lfsr[0];
      lfsr        = lfsr_step(lfsr);
      lat_bits[0] = lfsr[0];
      lfsr        = lfsr_step(lfsr);
      lat_bits[1] = lfsr[0];
      hst_ready   = ready_bit;
      rd_lat      = lat_bits;
    end else begin
      hst_ready = 1'b1;
      rd_lat    = 2'd0;
    end
  end

  // beat n of a phase belongs to command n / (len + 1) at position n % (len + 1)
  always @(negedge clk) begin
    if (rst_n && hst_valid && hst_ready) begin
      if (beat_n >= total_beats) begin
        $display("host port carried a beat beyond the programmed number of beats");
        stop_on_error();
      end
      bpp = cur_count * (cur_len + 1);
      idx = beat_n % bpp;
      k   = idx / (cur_len + 1);
      i   = idx % (cur_len + 1);
      if (cur_mode == mode_read || (cur_mode == mode_write_read && beat_n >= bpp)) begin
        exp_op = op_read;
      end else begin
        exp_op = op_write;
      end
      check_op(hst_write ? op_write : op_read, exp_op, "beat op");
      check_data(hst_addr, cur_base + `PCIM_ADDR_W'(idx * 4), "beat address");
      if (exp_op == op_write) begin
        check_data(hst_wdata, cur_seed + `PCIM_DATA_W'(k + i), "write data");
      end
      check_flag(hst_last, (i == cur_len), "hst_last");
      beat_n = beat_n + 1;
    end
  end

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    rst_n       = 1'b0;
    cfg_addr    = '0;
    cfg_wdata   = '0;
    cfg_wr      = 1'b0;
    cfg_rd      = 1'b0;
    hst_ready   = 1'b1;
    rd_lat      = 2'd0;
    corrupt     = 1'b0;
    bp_on       = 1'b0;
    lfsr        = 32'hcccd_9c36;
    beat_n      = 0;
    total_beats = 0;
    cur_mode    = mode_write;
    cur_base    = '0;
    cur_seed    = '0;
    cur_len     = 0;
    cur_count   = 0;

    // mode, base, len, count, seed, corrupt, back-pressure, expected errors
    programs[0] = '{mode_write,      32'h0000_1000, 8'd3, 16'd4, 32'h0000_0100, 1'b0, 1'b0, 16'd0};
    programs[1] = '{mode_read,       32'h0000_1000, 8'd3, 16'd4, 32'h0000_0100, 1'b0, 1'b0, 16'd0};
    programs[2] = '{mode_write_read, 32'h0000_2000, 8'd7, 16'd5, 32'habc0_0000, 1'b1, 1'b0, 16'd3};
    programs[3] = '{mode_write_read, 32'h0000_3000, 8'd2, 16'd6, 32'h5555_0000, 1'b0, 1'b1, 16'd0};
    programs[4] = '{mode_write_read, 32'h0000_4030, 8'd0, 16'd9, 32'h0000_7f00, 1'b1, 1'b1, 16'd1};
    programs[5] = '{mode_read,       32'h0000_2000, 8'd7, 16'd5, 32'habc0_0000, 1'b0, 1'b1, 16'd3};

    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;

    @(negedge clk);
    check_flag(hst_valid, 1'b0, "hst_valid after reset");
    check_flag(cfg_ack, 1'b0, "cfg_ack after reset");
    @(posedge clk);
    #1;
    cfg_read(`PCIM_REG_STATUS, rd_word);
    check_flag(rd_word[0], 1'b0, "busy after reset");
    check_count(rd_word[31:16], '0, "cmds_done after reset");
    cfg_read(`PCIM_REG_ERRS, rd_word);
    check_count(rd_word[`PCIM_CNT_W-1:0], '0, "err_count after reset");

    // the narrow fields keep only their low bits, ctrl bit 0 stays clear
    write_and_read_back(`PCIM_REG_BASE, 32'h8765_4320, 32'h8765_4320);
    write_and_read_back(`PCIM_REG_LEN, 32'hffff_ff5a, 32'h0000_005a);
    write_and_read_back(`PCIM_REG_COUNT, 32'habcd_1234, 32'h0000_1234);
    write_and_read_back(`PCIM_REG_SEED, 32'h1357_9bdf, 32'h1357_9bdf);
    write_and_read_back(`PCIM_REG_MODE, 32'h0000_0002, 32'h0000_0002);
    write_and_read_back(`PCIM_REG_CTRL, 32'h0000_00a4, 32'h0000_00a4);

    for (int r = 0; r < NUM_PROGRAMS; r++) begin
      run_program(programs[r]);
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* src.f */
+incdir+source
source/pcim_pkg.sv
source/pcim_cmd_if.sv
source/pcim_atg.sv
source/pcim_flop_fifo.sv
source/pcim_beat_engine.sv
source/pcim_mstr.sv
test/pcim_host_model.sv
test/tb_pcim_mstr.sv

/* Bender.yml */
package:
  name: pcim_mstr

sources:
  - include_dirs:
      - source
    files:
      - source/pcim_pkg.sv
      - source/pcim_cmd_if.sv
      - source/pcim_atg.sv
      - source/pcim_flop_fifo.sv
      - source/pcim_beat_engine.sv
      - source/pcim_mstr.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/pcim_host_model.sv
      - test/tb_pcim_mstr.sv
